/* design/parking_defs.svh */
`ifndef PARKING_DEFS_SVH
`define PARKING_DEFS_SVH

// Tower geometry
`define PARK_FLOORS 7       // Parking floors above the lobby
`define PLATE_W 16

// Order queue
`define QUEUE_DEPTH 7

// Billing
`define FEE_W 8
`define METER_W 16          // Parked-cycle counter per place

// Plate classes, taken from the top nibble of the plate
`define DISABLED_NIBBLE 4'd9
`define HYBRID_NIBBLE 4'd8

`endif

/* design/tower_pkg.sv */
`default_nettype none

`include "parking_defs.svh"

package tower_pkg;
    localparam int NUM_PLACES = 2 * (`PARK_FLOORS + 1);  // Lobby pair included
    localparam int FIRST_PLACE = 2;                       // Floor 1 left

    typedef logic [2:0] floor_t;
    typedef logic [`PLATE_W-1:0] plate_t;   // Zero means no car
    typedef logic [3:0] place_t;            // {floor, side}, side 0 is left
    typedef logic [`FEE_W-1:0] fee_t;
    typedef logic [3:0] count_t;
    typedef logic [NUM_PLACES-1:0] place_vec_t;

    function automatic floor_t place_floor(place_t p);
        return p[3:1];
    endfunction

    // Odd floors take SUVs
    function automatic logic suv_floor(floor_t f);
        return f[0];
    endfunction

    // Left places of floors 1 and 2 are kept for disabled drivers
    function automatic logic reserved_place(place_t p);
        return (p[0] == 1'b0) && (p[3:1] == 3'd1 || p[3:1] == 3'd2);
    endfunction

    function automatic logic disabled_plate(plate_t pl);
        return pl[`PLATE_W-1 -: 4] == `DISABLED_NIBBLE;
    endfunction

    function automatic logic hybrid_plate(plate_t pl);
        return pl[`PLATE_W-1 -: 4] == `HYBRID_NIBBLE;
    endfunction
endpackage

`default_nettype wire

/* design/elevator_pkg.sv */
`default_nettype none

package elevator_pkg;
    typedef enum logic [1:0] {
        order_none,
        order_park,
        order_fetch
    } order_e;

    typedef enum logic [3:0] {
        st_idle,
        st_load,       // Car rolls onto the platform
        st_climb,
        st_park,
        st_return,
        st_seek,       // Empty trip up to a parked car
        st_pick,
        st_descend,
        st_deliver
    } state_e;
endpackage

`default_nettype wire

/* design/order_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "parking_defs.svh"

module order_queue (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_mode,
    input  logic                 out_mode,
    input  tower_pkg::plate_t    plate,
    input  logic                 take,
    output logic                 pending,
    output elevator_pkg::order_e order_kind,
    output tower_pkg::plate_t    order_plate
);
    import tower_pkg::*;
    import elevator_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    order_e kind_mem [`QUEUE_DEPTH];
    plate_t plate_mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic push;
    logic pop;

    // Full queue drops the incoming order
    assign push = (in_mode || out_mode) && (fill != CNT_W'(`QUEUE_DEPTH));
    assign pop = take && pending;
    assign pending = fill != '0;
    assign order_kind = kind_mem[rd_ptr];
    assign order_plate = plate_mem[rd_ptr];

    function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
        end else begin
            if (push)
                wr_ptr <= bump(wr_ptr);
            if (pop)
                rd_ptr <= bump(rd_ptr);
            fill <= fill + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            kind_mem[wr_ptr] <= in_mode ? order_park : (out_mode ? order_fetch : order_none);
            plate_mem[wr_ptr] <= plate;
        end
    end

endmodule

`default_nettype wire

/* design/floor_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "parking_defs.svh"

module floor_counter (
    input  logic              clock,
    input  logic              reset,
    input  logic              move_up,
    input  logic              move_down,
    output tower_pkg::floor_t current_floor
);
    import tower_pkg::*;

    localparam floor_t TOP_FLOOR = floor_t'(`PARK_FLOORS);

    // One floor per cycle, held at the lobby and the roof
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            current_floor <= '0;
        end else if (move_up && current_floor != TOP_FLOOR) begin
            current_floor <= current_floor + 1'b1;
        end else if (move_down && current_floor != '0) begin
            current_floor <= current_floor - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/elevator_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module elevator_fsm (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 pending,
    input  elevator_pkg::order_e order_kind,
    input  tower_pkg::plate_t    order_plate,
    input  tower_pkg::place_t    free_place,
    input  logic                 free_found,
    input  tower_pkg::place_t    found_place,
    input  logic                 plate_found,
    input  tower_pkg::floor_t    current_floor,
    output logic                 take,
    output logic                 move_up,
    output logic                 move_down,
    output logic                 store_write,
    output tower_pkg::place_t    store_place,
    output tower_pkg::plate_t    store_plate,
    output tower_pkg::plate_t    carried_plate,
    output logic                 parked,
    output tower_pkg::place_t    parked_spot,
    output logic                 car_out_ready
);
    import tower_pkg::*;
    import elevator_pkg::*;

    state_e state;
    state_e state_next;
    plate_t job_plate;      // Plate of the order in progress
    place_t target;
    floor_t target_floor;
    logic   last_up;        // This step reaches the target floor
    logic   last_down;      // This step reaches the lobby

    assign target_floor = place_floor(target);
    assign last_up = floor_t'(current_floor + 1'b1) == target_floor;
    assign last_down = current_floor == floor_t'(1);

    assign take = (state == st_idle) && pending;
    assign move_up = (state == st_climb || state == st_seek) && (current_floor != target_floor);
    assign move_down = (state == st_return || state == st_descend) && (current_floor != '0);

    assign parked = state == st_park;
    assign parked_spot = target;
    assign car_out_ready = state == st_deliver;

    // Park writes the plate, pick writes zero
    assign store_write = (state == st_park) || (state == st_pick);
    assign store_place = target;
    assign store_plate = (state == st_park) ? job_plate : '0;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                // An order with no place or no matching car is simply consumed
                if (take && order_kind == order_park && free_found)
                    state_next = st_load;
                else if (take && order_kind == order_fetch && plate_found)
                    state_next = st_seek;
            end
            st_load:    state_next = st_climb;
            st_climb:   if (last_up) state_next = st_park;
            st_park:    state_next = st_return;
            st_return:  if (last_down) state_next = st_idle;
            st_seek:    if (last_up) state_next = st_pick;
            st_pick:    state_next = st_descend;
            st_descend: if (last_down) state_next = st_deliver;
            st_deliver: state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            carried_plate <= '0;
        end else begin
            state <= state_next;
            case (state)
                st_load, st_pick:    carried_plate <= job_plate;  // Car on the platform
                st_park, st_deliver: carried_plate <= '0;
                default: ;
            endcase
        end
    end

    // Order and target captured at the head of the queue
    always_ff @(posedge clock) begin
        if (take) begin
            job_plate <= order_plate;
            target <= (order_kind == order_park) ? free_place : found_place;
        end
    end

endmodule

`default_nettype wire

/* design/slot_store.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_store (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  store_write,
    input  tower_pkg::place_t     store_place,
    input  tower_pkg::plate_t     store_plate,
    input  tower_pkg::plate_t     query_plate,
    output tower_pkg::place_t     free_place,
    output logic                  free_found,
    output tower_pkg::place_t     found_place,
    output logic                  plate_found,
    output tower_pkg::place_vec_t occupied,
    output tower_pkg::count_t     empty_suv,
    output tower_pkg::count_t     empty_sedan,
    output logic                  full_suv,
    output logic                  full_sedan
);
    import tower_pkg::*;

    plate_t slots [FIRST_PLACE:NUM_PLACES-1];   // The lobby has no places
    logic   query_suv;
    logic   query_disabled;

    assign query_suv = query_plate[0];
    assign query_disabled = disabled_plate(query_plate);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int p = FIRST_PLACE; p < NUM_PLACES; p++)
                slots[p] <= '0;
        end else if (store_write && store_place >= place_t'(FIRST_PLACE)) begin
            slots[store_place] <= store_plate;
        end
    end

    always_comb begin
        occupied = '0;
        for (int p = FIRST_PLACE; p < NUM_PLACES; p++)
            occupied[p] = slots[p] != '0;
    end

    // Reserved places are left out of both counts
    always_comb begin
        empty_suv = '0;
        empty_sedan = '0;
        for (int p = FIRST_PLACE; p < NUM_PLACES; p++) begin
            if (!occupied[p] && !reserved_place(place_t'(p))) begin
                if (suv_floor(place_floor(place_t'(p))))
                    empty_suv = empty_suv + 1'b1;
                else
                    empty_sedan = empty_sedan + 1'b1;
            end
        end
    end

    assign full_suv = empty_suv == '0;
    assign full_sedan = empty_sedan == '0;

    // Walk downward so the lowest index wins, which gives lowest floor, then left
    always_comb begin
        logic floor_ok;
        logic side_ok;
        free_found = 1'b0;
        free_place = '0;
        plate_found = 1'b0;
        found_place = '0;
        for (int p = NUM_PLACES - 1; p >= FIRST_PLACE; p--) begin
            floor_ok = suv_floor(place_floor(place_t'(p))) ? (query_suv || full_sedan)
                                                           : !query_suv;
            side_ok = !reserved_place(place_t'(p)) || query_disabled;
            if (!occupied[p] && floor_ok && side_ok) begin
                free_found = 1'b1;
                free_place = place_t'(p);
            end
            if (query_plate != '0 && slots[p] == query_plate) begin
                plate_found = 1'b1;
                found_place = place_t'(p);
            end
        end
    end

endmodule

`default_nettype wire

/* design/fee_meter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "parking_defs.svh"

module fee_meter (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  store_write,
    input  tower_pkg::place_t     store_place,
    input  tower_pkg::plate_t     store_plate,
    input  tower_pkg::place_vec_t occupied,
    output tower_pkg::fee_t       fee
);
    import tower_pkg::*;

    localparam int RAW_W = `METER_W + 2;
    localparam fee_t FEE_MAX = '1;

    logic [`METER_W-1:0] meter [NUM_PLACES];
    logic [1:0]          rate [NUM_PLACES];    // Fee units per parked cycle
    logic [`METER_W:0]   elapsed;
    logic [RAW_W-1:0]    raw_fee;
    logic                park_write;
    logic                free_write;

    assign park_write = store_write && store_plate != '0;
    assign free_write = store_write && store_plate == '0;

    // The pick cycle itself still counts as parked
    assign elapsed = {1'b0, meter[store_place]} + 1'b1;
    assign raw_fee = RAW_W'(elapsed) * RAW_W'(rate[store_place]);

    function automatic logic [1:0] plate_rate(plate_t pl);
        if (disabled_plate(pl))
            return 2'd0;
        if (hybrid_plate(pl))
            return 2'd1;
        return 2'd2;
    endfunction

    always_ff @(posedge clock) begin
        for (int p = 0; p < NUM_PLACES; p++) begin
            if (park_write && store_place == place_t'(p)) begin
                meter[p] <= '0;
                rate[p] <= plate_rate(store_plate);
            end else if (occupied[p] && meter[p] != '1) begin
                meter[p] <= meter[p] + 1'b1;    // Saturates at all ones
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            fee <= '0;
        else if (free_write)
            fee <= (raw_fee > RAW_W'(FEE_MAX)) ? FEE_MAX : fee_t'(raw_fee);
    end

endmodule

`default_nettype wire

/* design/parking_tower.sv */
`timescale 1ns/1ps
`default_nettype none

module parking_tower (
    input  logic              clock,
    input  logic              reset,
    input  tower_pkg::plate_t plate,
    input  logic              in_mode,
    input  logic              out_mode,
    output tower_pkg::floor_t current_floor,
    output tower_pkg::plate_t carried_plate,
    output logic              parked,
    output tower_pkg::place_t parked_spot,
    output logic              car_out_ready,
    output tower_pkg::fee_t   fee,
    output tower_pkg::count_t empty_suv,
    output tower_pkg::count_t empty_sedan,
    output logic              full_suv,
    output logic              full_sedan
);
    import tower_pkg::*;
    import elevator_pkg::*;

    // Queue head
    logic       pending;
    logic       take;
    order_e     order_kind;
    plate_t     order_plate;

    // Search results for the head plate
    place_t     free_place;
    logic       free_found;
    place_t     found_place;
    logic       plate_found;

    logic       move_up;
    logic       move_down;
    logic       store_write;
    place_t     store_place;
    plate_t     store_plate;
    place_vec_t occupied;

    order_queue u_queue (
        .clock(clock), .reset(reset),
        .in_mode(in_mode), .out_mode(out_mode), .plate(plate),
        .take(take), .pending(pending),
        .order_kind(order_kind), .order_plate(order_plate)
    );

    floor_counter u_floor (
        .clock(clock), .reset(reset),
        .move_up(move_up), .move_down(move_down),
        .current_floor(current_floor)
    );

    elevator_fsm u_fsm (
        .clock(clock), .reset(reset),
        .pending(pending), .order_kind(order_kind), .order_plate(order_plate),
        .free_place(free_place), .free_found(free_found),
        .found_place(found_place), .plate_found(plate_found),
        .current_floor(current_floor), .take(take),
        .move_up(move_up), .move_down(move_down),
        .store_write(store_write), .store_place(store_place), .store_plate(store_plate),
        .carried_plate(carried_plate), .parked(parked), .parked_spot(parked_spot),
        .car_out_ready(car_out_ready)
    );

    slot_store u_store (
        .clock(clock), .reset(reset),
        .store_write(store_write), .store_place(store_place), .store_plate(store_plate),
        .query_plate(order_plate),
        .free_place(free_place), .free_found(free_found),
        .found_place(found_place), .plate_found(plate_found),
        .occupied(occupied),
        .empty_suv(empty_suv), .empty_sedan(empty_sedan),
        .full_suv(full_suv), .full_sedan(full_sedan)
    );

    fee_meter u_meter (
        .clock(clock), .reset(reset),
        .store_write(store_write), .store_place(store_place), .store_plate(store_plate),
        .occupied(occupied), .fee(fee)
    );

endmodule

`default_nettype wire

/* verification/parking_tower_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module parking_tower_sva (
    input logic              clock,
    input logic              reset,
    input logic              parked,
    input logic              car_out_ready,
    input tower_pkg::floor_t current_floor
);

    // A trip either parks a car or delivers one
    a_single_event: assert property (@(posedge clock) disable iff (reset)
        !($rose(parked) && $rose(car_out_ready)))
        else $error("parked and car_out_ready rose in the same cycle");

    // Widened by one bit so a jump between the lobby and the roof does not wrap
    a_floor_step: assert property (@(posedge clock) disable iff (reset)
        current_floor == $past(current_floor) ||
        {1'b0, current_floor} == {1'b0, $past(current_floor)} + 4'd1 ||
        {1'b0, current_floor} + 4'd1 == {1'b0, $past(current_floor)})
        else $error("current_floor moved by more than one floor");

    a_deliver_lobby: assert property (@(posedge clock) disable iff (reset)
        car_out_ready |-> current_floor == '0)   // Cars leave at the lobby only
        else $error("car_out_ready away from the lobby");

endmodule

bind parking_tower parking_tower_sva u_sva (
    .clock(clock),
    .reset(reset),
    .parked(parked),
    .car_out_ready(car_out_ready),
    .current_floor(current_floor)
);

`default_nettype wire

/* verification/tb_parking_tower.sv */
`timescale 1ns/1ps
`default_nettype none

`include "parking_defs.svh"

module tb_parking_tower;
    import tower_pkg::*;

    localparam int EVENT_LIMIT = 3 * `PARK_FLOORS + 6;  // Longest wait for a trip pulse
    localparam int QUIET_LIMIT = 2 * `PARK_FLOORS + 4;  // Watch window for a discarded order
    localparam int NO_PLACE = -1;
    localparam int FEE_CAP = (1 << `FEE_W) - 1;

    logic   clock;
    logic   reset;
    plate_t plate;
    logic   in_mode;
    logic   out_mode;
    floor_t current_floor;
    plate_t carried_plate;
    logic   parked;
    place_t parked_spot;
    logic   car_out_ready;
    fee_t   fee;
    count_t empty_suv;
    count_t empty_sedan;
    logic   full_suv;
    logic   full_sedan;

    string  vec_op [$];
    plate_t vec_plate [$];
    int     vec_gap [$];

    plate_t      model_slot [NUM_PLACES];   // Zero for a free place
    int          park_cycle [NUM_PLACES];
    int          cycle;
    int          errors;
    int          failed_tests;
    logic [31:0] rng_state;
    logic        loaded;

    parking_tower dut (
        .clock(clock), .reset(reset),
        .plate(plate), .in_mode(in_mode), .out_mode(out_mode),
        .current_floor(current_floor), .carried_plate(carried_plate),
        .parked(parked), .parked_spot(parked_spot),
        .car_out_ready(car_out_ready), .fee(fee),
        .empty_suv(empty_suv), .empty_sedan(empty_sedan),
        .full_suv(full_suv), .full_sedan(full_sedan)
    );

    always #2 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERR %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycle);
        errors++;
    endtask

    task automatic report_problem(string what);
        $display("error at cycle %0d: %s", cycle, what);
        errors++;
    endtask

    // Free places outside the disabled reservation, per floor type
    function automatic int free_unreserved(bit odd_floors);
        int n;
        n = 0;
        for (int f = 1; f <= `PARK_FLOORS; f++) begin
            for (int s = 0; s < 2; s++) begin
                if ((f % 2 == 1) == odd_floors && model_slot[2*f+s] == '0 && !(s == 0 && f <= 2))
                    n++;
            end
        end
        return n;
    endfunction

    // Lowest floor first, left before right
    function automatic int choose_place(plate_t pl);
        bit is_suv;
        bit is_disabled;
        bit sedans_full;
        bit floor_ok;
        is_suv = pl[0];
        is_disabled = pl[`PLATE_W-1 -: 4] == `DISABLED_NIBBLE;
        sedans_full = free_unreserved(1'b0) == 0;
        for (int f = 1; f <= `PARK_FLOORS; f++) begin
            floor_ok = (f % 2 == 1) ? (is_suv || sedans_full) : !is_suv;
            for (int s = 0; s < 2; s++) begin
                if (floor_ok && model_slot[2*f+s] == '0 && (is_disabled || s == 1 || f > 2))
                    return 2 * f + s;
            end
        end
        return NO_PLACE;
    endfunction

    function automatic int locate_plate(plate_t pl);
        for (int p = 2; p < NUM_PLACES; p++) begin
            if (model_slot[p] == pl)
                return p;
        end
        return NO_PLACE;
    endfunction

    function automatic int expected_fee(plate_t pl, int elapsed);
        int rate;
        int amount;
        if (pl[`PLATE_W-1 -: 4] == `DISABLED_NIBBLE)
            rate = 0;
        else if (pl[`PLATE_W-1 -: 4] == `HYBRID_NIBBLE)
            rate = 1;
        else
            rate = 2;
        amount = rate * elapsed;
        return (amount > FEE_CAP) ? FEE_CAP : amount;
    endfunction

    task automatic read_vectors(output bit ok);
        int          fd;
        string       text;
        string       op;
        logic [31:0] pl;
        int          gap;
        fd = $fopen("verification/parking_vectors.txt", "r");
        ok = fd != 0;
        if (ok) begin
            while ($fgets(text, fd) != 0) begin
                if (text[0] != "#" && $sscanf(text, "%s %h %d", op, pl, gap) == 3) begin
                    vec_op.push_back(op);
                    vec_plate.push_back(plate_t'(pl));
                    vec_gap.push_back(gap);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_counts();
        int suv_free;
        int sedan_free;
        suv_free = free_unreserved(1'b1);
        sedan_free = free_unreserved(1'b0);
        if (empty_suv != count_t'(suv_free))
            report_mismatch("empty_suv", 32'(empty_suv), 32'(suv_free));
        if (empty_sedan != count_t'(sedan_free))
            report_mismatch("empty_sedan", 32'(empty_sedan), 32'(sedan_free));
        if (full_suv != (suv_free == 0))
            report_mismatch("full_suv", 32'(full_suv), 32'(suv_free == 0));
        if (full_sedan != (sedan_free == 0))
            report_mismatch("full_sedan", 32'(full_sedan), 32'(sedan_free == 0));
    endtask

    task automatic check_reset();
        int errors_before;
        errors_before = errors;
        if (current_floor != '0)
            report_mismatch("current_floor", 32'(current_floor), 32'h0);
        if (fee != '0)
            report_mismatch("fee", 32'(fee), 32'h0);
        if (carried_plate != '0)
            report_mismatch("carried_plate", 32'(carried_plate), 32'h0);
        if (parked || car_out_ready)
            report_problem("trip pulse right after reset");
        check_counts();
        $display("reset state: %s", (errors == errors_before) ? "pass" : "FAIL");
        if (errors != errors_before)
            failed_tests++;
    endtask

    // Called on the cycle that carries a parked or car_out_ready pulse
    task automatic check_event(bit is_park, plate_t pl, int exp_place);
        int f;
        int elapsed;
        f = exp_place / 2;
        if (exp_place == NO_PLACE) begin
            report_problem($sformatf("trip pulse for discarded order of plate %h", pl));
        end else if (is_park) begin
            if (!parked || car_out_ready)
                report_problem("car_out_ready instead of parked for a park order");
            if (parked_spot != place_t'(exp_place))
                report_mismatch("parked_spot", 32'(parked_spot), 32'(exp_place));
            if (current_floor != floor_t'(f))
                report_mismatch("current_floor", 32'(current_floor), 32'(f));
            if (carried_plate != pl)
                report_mismatch("carried_plate", 32'(carried_plate), 32'(pl));
            park_cycle[exp_place] = cycle;
        end else begin
            if (!car_out_ready || parked)
                report_problem("parked instead of car_out_ready for a fetch order");
            elapsed = cycle - park_cycle[exp_place] - (f + 1);  // Trip time is not billed
            if (fee != fee_t'(expected_fee(pl, elapsed)))
                report_mismatch("fee", 32'(fee), 32'(expected_fee(pl, elapsed)));
            if (carried_plate != pl)
                report_mismatch("carried_plate", 32'(carried_plate), 32'(pl));
        end
    endtask

    task automatic run_order(int idx);
        bit     is_park;
        bit     seen;
        plate_t pl;
        int     exp_place;
        int     limit;
        int     errors_before;
        errors_before = errors;
        is_park = vec_op[idx] == "park";
        if (!is_park && vec_op[idx] != "fetch")
            report_problem($sformatf("unknown opcode %s in vector %0d", vec_op[idx], idx + 1));
        pl = vec_plate[idx];
        if (pl == '0) begin
            rng_state = xorshift(rng_state);
            pl = (rng_state[15:0] == '0) ? plate_t'(1) : rng_state[15:0];
        end
        exp_place = is_park ? choose_place(pl) : locate_plate(pl);
        if (exp_place != NO_PLACE)
            model_slot[exp_place] = is_park ? pl : '0;

        repeat (vec_gap[idx] + 1) @(posedge clock);
        plate <= pl;
        in_mode <= is_park;
        out_mode <= !is_park;
        @(posedge clock);
        in_mode <= 1'b0;
        out_mode <= 1'b0;

        limit = (exp_place == NO_PLACE) ? QUIET_LIMIT : EVENT_LIMIT;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clock);
            if (parked || car_out_ready) begin
                seen = 1'b1;
                check_event(is_park, pl, exp_place);
            end
        end
        if (!seen && exp_place != NO_PLACE)
            report_problem($sformatf("no trip pulse within %0d cycles for plate %h", limit, pl));
        @(negedge clock);                   // Store write has landed
        check_counts();
        $display("order %0d %s %h: %s", idx + 1, vec_op[idx], pl,
                 (errors == errors_before) ? "pass" : "FAIL");
        if (errors != errors_before)
            failed_tests++;
    endtask

    initial begin
        bit ok;
        clock = 1'b0;
        reset = 1'b1;
        plate = '0;
        in_mode = 1'b0;
        out_mode = 1'b0;
        cycle = 0;
        errors = 0;
        failed_tests = 0;
        rng_state = 32'h85751166;
        loaded = 1'b0;
        for (int p = 0; p < NUM_PLACES; p++) begin
            model_slot[p] = '0;
            park_cycle[p] = 0;
        end
        read_vectors(ok);
        if (!ok) begin
            $display("cannot open verification/parking_vectors.txt");
            $display("test failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clock);
            reset <= 1'b0;
            @(negedge clock);
            check_reset();
            for (int i = 0; i < vec_op.size(); i++)
                run_order(i);
            $display("summary: %0d tests, %0d failing, %0d errors",
                     vec_op.size() + 1, failed_tests, errors);
            if (errors == 0)
                $display("test passed");
            else
                $display("test failed");
            $finish;
        end
    end

    // Bound from the vector count and the longest idle gap
    initial begin
        int     max_gap;
        longint limit_ns;
        wait (loaded);
        max_gap = 0;
        foreach (vec_gap[i]) begin
            if (vec_gap[i] > max_gap)
                max_gap = vec_gap[i];
        end
        limit_ns = (longint'(vec_gap.size()) * (2 * `PARK_FLOORS + 4 + max_gap) + 100) * 4;
        #(limit_ns);
        $display("timeout: run still going after %0d ns", limit_ns);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/parking_vectors.txt */
# opcode (park or fetch), plate in hex, idle cycles before the order
# plate 0000 draws a random plate from the testbench generator
park 1A01 2
park 2B02 0
park 8E42 1
fetch 8E42 4
park 9C11 0
park 9D20 0
park 8E42 0
park 3F54 3
park 4A66 0
park 5B78 0
park 6C8A 0
park 7D91 1
park 1E03 0
park 2F05 0
park 3A07 0
park 4B09 0
park 5C0B 0
park 6D0C 2
fetch 4B09 0
fetch 0000 0
fetch 9C11 2
fetch 8E42 0
fetch 2B02 60
park 7E0E 0
fetch 6C8A 1

/* parking_tower.f */
+incdir+design
design/tower_pkg.sv
design/elevator_pkg.sv
design/order_queue.sv
design/floor_counter.sv
design/elevator_fsm.sv
design/slot_store.sv
design/fee_meter.sv
design/parking_tower.sv
verification/parking_tower_sva.sv
verification/tb_parking_tower.sv

/* Makefile */
# Verilator build and run of the parking tower testbench

VERILATOR ?= verilator
TOP       ?= tb_parking_tower
FILELIST  ?= parking_tower.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= test passed
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
